// ==== src/holy_core_cfg.svh ====
`ifndef HOLY_CORE_CFG_SVH
`define HOLY_CORE_CFG_SVH

// Data and address width
`define HC_XLEN 32

// Architectural registers, x0 included
`define HC_NREGS 32

// First fetch address after reset
`define HC_RESET_PC 32'h0000_0000

`endif

// ==== src/holy_core_pkg.sv ====
package holy_core_pkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OPCODE_R_TYPE       = 7'b0110011,
        OPCODE_I_TYPE_ALU   = 7'b0010011,
        OPCODE_I_TYPE_LOAD  = 7'b0000011,
        OPCODE_S_TYPE       = 7'b0100011,
        OPCODE_B_TYPE       = 7'b1100011,
        OPCODE_U_TYPE_LUI   = 7'b0110111,
        OPCODE_U_TYPE_AUIPC = 7'b0010111,
        OPCODE_J_TYPE       = 7'b1101111,
        OPCODE_J_TYPE_JALR  = 7'b1100111
    } opcode_t;

    // ALU function codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_SLL_SRL = 7'b0000000;
    localparam logic [6:0] F7_SRA     = 7'b0100000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [1:0] {
        ALU_OP_LOAD_STORE = 2'b00,
        ALU_OP_BRANCHES   = 2'b01,
        ALU_OP_MATH       = 2'b10
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_XOR  = 4'b1000,
        ALU_SRA  = 4'b1001,
        ALU_NONE = 4'b1111
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_PC4  = 2'b10,
        WB_ADD2 = 2'b11
    } wb_src_t;

    // Base operand of the second adder
    localparam logic [1:0] SA_PC   = 2'b00;
    localparam logic [1:0] SA_ZERO = 2'b01;
    localparam logic [1:0] SA_RS1  = 2'b10;

    typedef struct packed {
        alu_ctrl_t  alu_control;
        imm_src_t   imm_source;
        logic       mem_write;
        logic       reg_write;
        logic       alu_source;
        wb_src_t    write_back_source;
        logic       pc_source;
        logic [1:0] second_add_source;
    } ctrl_t;

    // Same 32-bit word seen through the different encodings
    typedef union packed {
        struct packed {
            logic [6:0] func7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] rd;
            opcode_t    op;
        } r_fields;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            opcode_t     op;
        } i_fields;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            opcode_t     op;
        } u_fields;
        logic [31:0] raw;
    } instr_t;

endpackage

// ==== src/control.sv ====
`timescale 1ns/10ps

module control (
    input  holy_core_pkg::opcode_t op,
    input  logic [2:0]             func3,
    input  logic [6:0]             func7,
    input  logic                   alu_zero,
    input  logic                   alu_last_bit,
    output holy_core_pkg::ctrl_t   ctrl
);

    import holy_core_pkg::*;

    alu_op_t    alu_op;
    alu_ctrl_t  alu_control;
    imm_src_t   imm_source;
    wb_src_t    write_back_source;
    logic       mem_write;
    logic       reg_write;
    logic       alu_source;
    logic [1:0] second_add_source;
    logic       branch;
    logic       jump;
    logic       take_branch;

    // Main decoder
    always_comb begin
        // Safe defaults, also used for unknown opcodes
        alu_op            = ALU_OP_LOAD_STORE;
        imm_source        = IMM_I;
        mem_write         = 1'b0;
        reg_write         = 1'b0;
        alu_source        = 1'b0;
        write_back_source = WB_ALU;
        second_add_source = SA_PC;
        branch            = 1'b0;
        jump              = 1'b0;
        case (op)
            OPCODE_I_TYPE_LOAD: begin
                reg_write         = 1'b1;
                alu_source        = 1'b1;
                write_back_source = WB_MEM;
            end
            OPCODE_I_TYPE_ALU: begin
                alu_op     = ALU_OP_MATH;
                alu_source = 1'b1;
                // Shift immediates carry a func7 in the upper bits, only a few are legal
                if (func3 == F3_SLL) begin
                    reg_write = (func7 == F7_SLL_SRL);
                end else if (func3 == F3_SRL_SRA) begin
                    reg_write = (func7 == F7_SLL_SRL) || (func7 == F7_SRA);
                end else begin
                    reg_write = 1'b1;
                end
            end
            OPCODE_S_TYPE: begin
                imm_source = IMM_S;
                mem_write  = 1'b1;
                alu_source = 1'b1;
            end
            OPCODE_R_TYPE: begin
                reg_write = 1'b1;
                alu_op    = ALU_OP_MATH;
            end
            OPCODE_B_TYPE: begin
                imm_source = IMM_B;
                alu_op     = ALU_OP_BRANCHES;
                branch     = 1'b1;
            end
            OPCODE_J_TYPE: begin
                reg_write         = 1'b1;
                imm_source        = IMM_J;
                write_back_source = WB_PC4;
                jump              = 1'b1;
            end
            OPCODE_J_TYPE_JALR: begin
                reg_write         = 1'b1;
                write_back_source = WB_PC4;
                second_add_source = SA_RS1;
                jump              = 1'b1;
            end
            OPCODE_U_TYPE_LUI: begin
                reg_write         = 1'b1;
                imm_source        = IMM_U;
                write_back_source = WB_ADD2;
                second_add_source = SA_ZERO;
            end
            OPCODE_U_TYPE_AUIPC: begin
                reg_write         = 1'b1;
                imm_source        = IMM_U;
                write_back_source = WB_ADD2;
            end
            default: begin
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_control = ALU_NONE;
        case (alu_op)
            ALU_OP_LOAD_STORE: alu_control = ALU_ADD;
            ALU_OP_MATH: begin
                case (func3)
                    // addi never subtracts
                    F3_ADD_SUB: begin
                        if (op == OPCODE_R_TYPE && func7 == F7_SUB) begin
                            alu_control = ALU_SUB;
                        end else begin
                            alu_control = ALU_ADD;
                        end
                    end
                    F3_SLL:  alu_control = ALU_SLL;
                    F3_SLT:  alu_control = ALU_SLT;
                    F3_SLTU: alu_control = ALU_SLTU;
                    F3_XOR:  alu_control = ALU_XOR;
                    F3_OR:   alu_control = ALU_OR;
                    F3_AND:  alu_control = ALU_AND;
                    F3_SRL_SRA: begin
                        if (func7 == F7_SRA) begin
                            alu_control = ALU_SRA;
                        end else if (func7 == F7_SLL_SRL) begin
                            alu_control = ALU_SRL;
                        end
                    end
                    default: alu_control = ALU_NONE;
                endcase
            end
            ALU_OP_BRANCHES: begin
                case (func3)
                    F3_BEQ, F3_BNE:   alu_control = ALU_SUB;
                    F3_BLT, F3_BGE:   alu_control = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_control = ALU_SLTU;
                    default:          alu_control = ALU_NONE;
                endcase
            end
            default: alu_control = ALU_NONE;
        endcase
    end

    // Branch decision from the ALU flags
    always_comb begin
        case (func3)
            F3_BEQ:           take_branch = branch & alu_zero;
            F3_BNE:           take_branch = branch & ~alu_zero;
            F3_BLT, F3_BLTU:  take_branch = branch & alu_last_bit;
            F3_BGE, F3_BGEU:  take_branch = branch & ~alu_last_bit;
            default:          take_branch = 1'b0;
        endcase
    end

    assign ctrl = '{
        alu_control:       alu_control,
        imm_source:        imm_source,
        mem_write:         mem_write,
        reg_write:         reg_write,
        alu_source:        alu_source,
        write_back_source: write_back_source,
        pc_source:         take_branch | jump,
        second_add_source: second_add_source
    };

endmodule

// ==== src/alu.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module alu (
    input  logic [`HC_XLEN-1:0]      a,
    input  logic [`HC_XLEN-1:0]      b,
    input  holy_core_pkg::alu_ctrl_t alu_control,
    output logic [`HC_XLEN-1:0]      result,
    output logic                     zero,
    output logic                     last_bit
);

    import holy_core_pkg::*;

    // Max shift is 31, so only 5 bits of b count
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_control)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {{(`HC_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`HC_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags feed the branch logic in control
    assign zero     = (result == '0);
    assign last_bit = result[0];

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic [`HC_XLEN-1:0] wdata,
    input  logic                we,
    output logic [`HC_XLEN-1:0] rdata1,
    output logic [`HC_XLEN-1:0] rdata2
);

    logic [`HC_XLEN-1:0] regs [`HC_NREGS];

    // Writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `HC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Asynchronous read ports, x0 hardwired to zero
    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[rs2];
        if (rs1 == 5'd0) begin
            rdata1 = '0;
        end
        if (rs2 == 5'd0) begin
            rdata2 = '0;
        end
    end

endmodule

// ==== src/imm_extend.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module imm_extend (
    input  holy_core_pkg::instr_t   instr,
    input  holy_core_pkg::imm_src_t imm_source,
    output logic [`HC_XLEN-1:0]     imm
);

    import holy_core_pkg::*;

    logic sign;

    // Sign bit sits at bit 31 in every format
    assign sign = instr.raw[31];

    always_comb begin
        case (imm_source)
            IMM_I: begin
                imm = {{(`HC_XLEN-12){sign}}, instr.i_fields.imm};
            end
            IMM_S: begin
                imm = {{(`HC_XLEN-12){sign}}, instr.raw[31:25], instr.raw[11:7]};
            end
            // Branch offsets are in halfwords, bit 0 is implicit
            IMM_B: begin
                imm = {{(`HC_XLEN-12){sign}}, instr.raw[7], instr.raw[30:25],
                       instr.raw[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{(`HC_XLEN-20){sign}}, instr.raw[19:12], instr.raw[20],
                       instr.raw[30:21], 1'b0};
            end
            // Upper 20 bits, low 12 cleared
            IMM_U: begin
                imm = {instr.u_fields.imm, 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== src/holy_core.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module holy_core (
    input  logic                clk,
    input  logic                rst,
    output logic [`HC_XLEN-1:0] imem_addr,
    input  logic [`HC_XLEN-1:0] imem_data,
    output logic [`HC_XLEN-1:0] dmem_addr,
    output logic [`HC_XLEN-1:0] dmem_wdata,
    output logic                dmem_we,
    input  logic [`HC_XLEN-1:0] dmem_rdata
);

    import holy_core_pkg::*;

    instr_t              instr;
    ctrl_t               ctrl;
    logic [`HC_XLEN-1:0] pc;
    logic [`HC_XLEN-1:0] pc_plus4;
    logic [`HC_XLEN-1:0] pc_next;
    logic [`HC_XLEN-1:0] rs1_data;
    logic [`HC_XLEN-1:0] rs2_data;
    logic [`HC_XLEN-1:0] imm;
    logic [`HC_XLEN-1:0] alu_b;
    logic [`HC_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic                alu_last_bit;
    logic [`HC_XLEN-1:0] add2_base;
    logic [`HC_XLEN-1:0] add2_sum;
    logic [`HC_XLEN-1:0] add2_target;
    logic [`HC_XLEN-1:0] wb_data;

    assign instr = imem_data;

    control u_control (
        .op           (instr.r_fields.op),
        .func3        (instr.r_fields.func3),
        .func7        (instr.r_fields.func7),
        .alu_zero     (alu_zero),
        .alu_last_bit (alu_last_bit),
        .ctrl         (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (instr.r_fields.rs1),
        .rs2    (instr.r_fields.rs2),
        .rd     (instr.r_fields.rd),
        .wdata  (wb_data),
        .we     (ctrl.reg_write),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    imm_extend u_imm_extend (
        .instr      (instr),
        .imm_source (ctrl.imm_source),
        .imm        (imm)
    );

    assign alu_b = ctrl.alu_source ? imm : rs2_data;

    alu u_alu (
        .a           (rs1_data),
        .b           (alu_b),
        .alu_control (ctrl.alu_control),
        .result      (alu_result),
        .zero        (alu_zero),
        .last_bit    (alu_last_bit)
    );

    // Second adder serves branches, jumps, lui and auipc
    always_comb begin
        case (ctrl.second_add_source)
            SA_ZERO: add2_base = '0;
            SA_RS1:  add2_base = rs1_data;
            default: add2_base = pc;
        endcase
    end

    assign add2_sum = add2_base + imm;
    // jalr target has bit 0 cleared
    assign add2_target = (ctrl.second_add_source == SA_RS1) ?
                         {add2_sum[`HC_XLEN-1:1], 1'b0} : add2_sum;

    assign pc_plus4 = pc + `HC_XLEN'd4;

    always_comb begin
        case (ctrl.write_back_source)
            WB_MEM:  wb_data = dmem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            WB_ADD2: wb_data = add2_target;
            default: wb_data = alu_result;
        endcase
    end

    assign pc_next = ctrl.pc_source ? add2_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `HC_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctrl.mem_write;

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

// ==== test/holy_core_checker.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module holy_core_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic [`HC_XLEN-1:0] imem_addr,
    input  logic [`HC_XLEN-1:0] dmem_addr,
    input  logic [`HC_XLEN-1:0] dmem_wdata,
    input  logic                dmem_we,
    input  logic [`HC_XLEN-1:0] exp_pc,
    input  logic                exp_we,
    input  logic [`HC_XLEN-1:0] exp_addr,
    input  logic [`HC_XLEN-1:0] exp_data,
    output int                  err_count,
    output int                  check_count
);

    int errs = 0;
    int checks = 0;
    // PC is unknown until the first rising edge loads the reset vector
    logic clocked = 1'b0;

    assign err_count   = errs;
    assign check_count = checks;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        clocked <= 1'b1;
    end

    // Sampled mid-cycle, once the combinational paths have settled
    always @(negedge clk) begin
        if (clocked) begin
            if (rst) begin
                check_value("imem_addr", imem_addr, `HC_RESET_PC);
                check_value("dmem_we", {31'b0, dmem_we}, 32'h0);
            end else begin
                check_value("imem_addr", imem_addr, exp_pc);
                check_value("dmem_we", {31'b0, dmem_we}, {31'b0, exp_we});
                if (exp_we) begin
                    check_value("dmem_addr", dmem_addr, exp_addr);
                    check_value("dmem_wdata", dmem_wdata, exp_data);
                end
            end
        end
    end

endmodule

// ==== test/holy_core_assert.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module holy_core_assert (
    input logic                clk,
    input logic                rst,
    input logic [`HC_XLEN-1:0] imem_addr,
    input logic                dmem_we
);

    int fail_count = 0;

    // No store may reach memory while the core is held in reset
    no_store_in_reset: assert property (@(posedge clk) rst |-> dmem_we !== 1'b1)
        else begin
            fail_count++;
            $error("dmem_we high during reset");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr not word aligned");
        end

    // First fetch after reset comes from the reset vector
    pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> imem_addr == `HC_RESET_PC)
        else begin
            fail_count++;
            $error("imem_addr not at reset vector after reset");
        end

endmodule

// ==== test/holy_core_tb.sv ====
`timescale 1ns/10ps

`include "holy_core_cfg.svh"

module holy_core_tb;

    localparam int          MAX_CYCLES = 200;
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [6:0]  OP_IMM     = 7'b0010011;
    localparam logic [6:0]  OP_LOAD    = 7'b0000011;
    localparam logic [6:0]  OP_JALR    = 7'b1100111;
    localparam logic [6:0]  OP_LUI     = 7'b0110111;
    localparam logic [6:0]  OP_AUIPC   = 7'b0010111;
    localparam logic [6:0]  OP_CUSTOM  = 7'b0001011;

    // One program word with the PC it must lead to and an optional store
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] next_pc;
        logic        st_we;
        logic [31:0] st_addr;
        logic [31:0] st_data;
    } entry_t;

    logic                clk;
    logic                rst;
    logic [`HC_XLEN-1:0] imem_addr;
    logic [`HC_XLEN-1:0] imem_data;
    logic [`HC_XLEN-1:0] dmem_addr;
    logic [`HC_XLEN-1:0] dmem_wdata;
    logic [`HC_XLEN-1:0] dmem_rdata;
    logic                dmem_we;
    entry_t              prog [64];
    int                  n_entries;
    logic [31:0]         dmem [64];
    logic [31:0]         exp_pc;
    logic [31:0]         final_pc;
    entry_t              cur;
    int                  err_count;
    int                  check_count;
    int                  assert_fails;
    int                  cycles;
    logic                timed_out;

    tb_clock u_clock (
        .clk (clk)
    );

    holy_core UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    holy_core_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .exp_pc      (exp_pc),
        .exp_we      (cur.st_we),
        .exp_addr    (cur.st_addr),
        .exp_data    (cur.st_data),
        .err_count   (err_count),
        .check_count (check_count)
    );

    bind holy_core holy_core_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we)
    );

    // Instruction memory beyond the program reads as NOP
    assign imem_data  = ((imem_addr >> 2) < n_entries) ? prog[imem_addr[7:2]].instr : NOP;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // RV32I encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw only, base register x0
    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic put(input logic [31:0] word, input logic [31:0] next_pc, input logic st_we,
                       input logic [31:0] st_addr, input logic [31:0] st_data);
        prog[n_entries] = '{word, next_pc, st_we, st_addr, st_data};
        n_entries++;
    endtask

    task automatic step(input logic [31:0] word);
        put(word, 4 * (n_entries + 1), 1'b0, '0, '0);
    endtask

    task automatic taken(input logic [31:0] word, input int offset);
        put(word, 4 * n_entries + offset, 1'b0, '0, '0);
    endtask

    task automatic store(input logic [4:0] rs2, input logic [11:0] addr,
                         input logic [31:0] data);
        put(s_word(addr, rs2), 4 * (n_entries + 1), 1'b1, {20'b0, addr}, data);
    endtask

    // x1 = 100, x2 = -7 feed most of the program
    task automatic build_program();
        n_entries = 0;
        step(NOP);
        step(i_word(12'd100, 5'd0, 3'b000, 5'd1, OP_IMM));
        step(i_word(12'hff9, 5'd0, 3'b000, 5'd2, OP_IMM));
        step(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        store(5'd3, 12'h080, 32'h0000_005d);
        step(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        store(5'd4, 12'h084, 32'h0000_006b);
        step(r_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        store(5'd5, 12'h088, 32'h0000_0060);
        step(r_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        store(5'd6, 12'h08c, 32'hffff_fffd);
        step(r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        store(5'd7, 12'h090, 32'hffff_ff9d);
        step(r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        store(5'd8, 12'h094, 32'h0000_0001);
        step(r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd8));
        store(5'd8, 12'h098, 32'h0000_0000);
        // Shift amounts are 25 from x2 and 4 from x1
        step(r_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd10));
        store(5'd10, 12'h09c, 32'hc800_0000);
        step(r_word(7'h00, 5'd1, 5'd2, 3'b101, 5'd11));
        store(5'd11, 12'h0a0, 32'h0fff_ffff);
        step(r_word(7'h20, 5'd1, 5'd2, 3'b101, 5'd12));
        store(5'd12, 12'h0a4, 32'hffff_ffff);
        step(i_word(12'h004, 5'd1, 3'b001, 5'd13, OP_IMM));
        // slli with func7 0x20 must leave x13 alone
        step(i_word(12'h408, 5'd1, 3'b001, 5'd13, OP_IMM));
        store(5'd13, 12'h0a8, 32'h0000_0640);
        // Taken branches skip one NOP that must never run
        step(b_word(13'd8, 5'd2, 5'd1, 3'b000));
        taken(b_word(13'd8, 5'd2, 5'd1, 3'b001), 8);
        step(NOP);
        taken(b_word(13'd8, 5'd1, 5'd2, 3'b100), 8);
        step(NOP);
        step(b_word(13'd8, 5'd2, 5'd1, 3'b100));
        taken(b_word(13'd8, 5'd2, 5'd1, 3'b101), 8);
        step(NOP);
        step(b_word(13'd8, 5'd1, 5'd2, 3'b101));
        taken(b_word(13'd8, 5'd2, 5'd1, 3'b110), 8);
        step(NOP);
        step(b_word(13'd8, 5'd1, 5'd2, 3'b110));
        taken(b_word(13'd8, 5'd1, 5'd2, 3'b111), 8);
        step(NOP);
        step(b_word(13'd8, 5'd2, 5'd1, 3'b111));
        taken(b_word(13'd8, 5'd1, 5'd1, 3'b000), 8);
        step(NOP);
        step(b_word(13'd8, 5'd1, 5'd1, 3'b001));
        taken(j_word(21'd12, 5'd14), 12);
        step(NOP);
        step(NOP);
        store(5'd14, 12'h0ac, 32'h0000_00b4);
        // 100 + 105 = 205, bit 0 dropped gives 0xcc
        taken(i_word(12'd105, 5'd1, 3'b000, 5'd15, OP_JALR), 12);
        step(NOP);
        step(NOP);
        store(5'd15, 12'h0b0, 32'h0000_00c4);
        step(u_word(20'h12345, 5'd16, OP_LUI));
        store(5'd16, 12'h0b4, 32'h1234_5000);
        step(u_word(20'h00001, 5'd17, OP_AUIPC));
        store(5'd17, 12'h0b8, 32'h0000_10d8);
        step(i_word(12'h020, 5'd0, 3'b010, 5'd18, OP_LOAD));
        store(5'd18, 12'h0bc, 32'h5a5a_0020);
        // Unknown opcode aimed at x1
        step(i_word(12'h123, 5'd1, 3'b000, 5'd1, OP_CUSTOM));
        store(5'd1, 12'h0c0, 32'h0000_0064);
        taken(j_word(21'd0, 5'd0), 0);
        final_pc = 4 * (n_entries - 1);
    endtask

    initial begin
        rst       = 1'b1;
        timed_out = 1'b0;
        cycles    = 0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'h5a5a_0000 | (i << 2);
        end
        exp_pc = `HC_RESET_PC;
        cur    = prog[exp_pc[7:2]];

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        while (imem_addr !== final_pc && !timed_out) begin
            @(posedge clk);
            #2;
            exp_pc = cur.next_pc;
            cur    = prog[exp_pc[7:2]];
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                timed_out = 1'b1;
                $display("Timeout: PC did not reach the final loop at %h within %0d cycles",
                         final_pc, MAX_CYCLES);
            end
        end
        // Let the checker see the final loop once
        @(posedge clk);
        #2;

        assert_fails = UUT.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_count, err_count, assert_fails, timed_out);
        if (err_count == 0 && assert_fails == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== holy_core.f ====
+incdir+src
src/holy_core_pkg.sv
src/control.sv
src/alu.sv
src/regfile.sv
src/imm_extend.sv
src/holy_core.sv
test/tb_clock.sv
test/holy_core_checker.sv
test/holy_core_assert.sv
test/holy_core_tb.sv

// ==== Bender.yml ====
package:
  name: holy_core

sources:
  - include_dirs:
      - src
    files:
      - src/holy_core_pkg.sv
      - src/control.sv
      - src/alu.sv
      - src/regfile.sv
      - src/imm_extend.sv
      - src/holy_core.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock.sv
      - test/holy_core_checker.sv
      - test/holy_core_assert.sv
      - test/holy_core_tb.sv
